/* compile.f */
+incdir+source
source/soc_bus_pkg.sv
source/soc_addr_decoder.sv
source/soc_bus_demux.sv
source/soc_bus_mux.sv
source/soc_bus.sv
tb/soc_bus_assertions.sv
tb/soc_bus_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f compile.f --top-module soc_bus_tb -o soc_bus_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/soc_bus_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

/* tb/soc_bus_tb.sv */
// Testbench top with target models, compare tasks, directed tests and watchdog
`include "soc_bus_settings.svh"

module soc_bus_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_CL = `SOC_N_CLUSTERS;
  localparam int N_L2 = `SOC_L2_N_PORTS;
  localparam int N_REQ = soc_bus_pkg::N_REQUESTERS;
  localparam int N_TGT = soc_bus_pkg::N_TARGETS;
  localparam int REQ_IDX_W = soc_bus_pkg::REQ_IDX_W;
  localparam int OUP_ID_W = soc_bus_pkg::OUP_ID_W;
  localparam logic [31:0] RD_KEY = 32'h5A5A_C3C3;
  localparam int PERIOD = 40;
  localparam int RSP_DELAY = 3;
  localparam int MAX_WAIT = 100;
  localparam int N_TESTS = 5;
  localparam int MAX_TEST_CYCLES = 1500;
  localparam int WATCHDOG_NS = (N_TESTS * MAX_TEST_CYCLES + 16) * PERIOD;

  logic clk_i = 1'b0;
  logic reset;
  soc_bus_pkg::slv_req_t [N_REQ-1:0] r_req;
  logic [N_REQ-1:0] r_valid;
  logic [N_REQ-1:0] r_ready;
  soc_bus_pkg::slv_rsp_t [N_REQ-1:0] r_rsp;
  logic [N_REQ-1:0] r_rsp_valid;
  logic [N_REQ-1:0] r_rsp_ready;
  soc_bus_pkg::mst_req_t [N_TGT-1:0] t_req;
  logic [N_TGT-1:0] t_req_valid;
  logic [N_TGT-1:0] t_req_ready;
  soc_bus_pkg::mst_rsp_t [N_TGT-1:0] t_rsp = '0;
  logic [N_TGT-1:0] t_rsp_valid = '0;
  logic [N_TGT-1:0] t_rsp_ready;

  // Target model state and scoreboard
  soc_bus_pkg::mst_req_t exp_q[N_TGT][$];
  soc_bus_pkg::mst_rsp_t rsp_q[N_TGT][$];
  int due_q[N_TGT][$];
  int grant_log[N_TGT][$];
  int rr_model[N_TGT];
  int accepts[N_TGT];
  int cycle = 0;
  int errors = 0;

  always #(PERIOD / 2) clk_i = ~clk_i;

  soc_bus uut (
    .clk_i,
    .reset,
    .cl_slv_req        (r_req[N_CL-1:0]),
    .cl_slv_req_valid  (r_valid[N_CL-1:0]),
    .cl_slv_req_ready  (r_ready[N_CL-1:0]),
    .cl_slv_rsp        (r_rsp[N_CL-1:0]),
    .cl_slv_rsp_valid  (r_rsp_valid[N_CL-1:0]),
    .cl_slv_rsp_ready  (r_rsp_ready[N_CL-1:0]),
    .rab_slv_req       (r_req[N_REQ-1]),
    .rab_slv_req_valid (r_valid[N_REQ-1]),
    .rab_slv_req_ready (r_ready[N_REQ-1]),
    .rab_slv_rsp       (r_rsp[N_REQ-1]),
    .rab_slv_rsp_valid (r_rsp_valid[N_REQ-1]),
    .rab_slv_rsp_ready (r_rsp_ready[N_REQ-1]),
    .cl_mst_req        (t_req[N_CL-1:0]),
    .cl_mst_req_valid  (t_req_valid[N_CL-1:0]),
    .cl_mst_req_ready  (t_req_ready[N_CL-1:0]),
    .cl_mst_rsp        (t_rsp[N_CL-1:0]),
    .cl_mst_rsp_valid  (t_rsp_valid[N_CL-1:0]),
    .cl_mst_rsp_ready  (t_rsp_ready[N_CL-1:0]),
    .l2_mst_req        (t_req[N_CL+N_L2-1:N_CL]),
    .l2_mst_req_valid  (t_req_valid[N_CL+N_L2-1:N_CL]),
    .l2_mst_req_ready  (t_req_ready[N_CL+N_L2-1:N_CL]),
    .l2_mst_rsp        (t_rsp[N_CL+N_L2-1:N_CL]),
    .l2_mst_rsp_valid  (t_rsp_valid[N_CL+N_L2-1:N_CL]),
    .l2_mst_rsp_ready  (t_rsp_ready[N_CL+N_L2-1:N_CL]),
    .rab_mst_req       (t_req[N_TGT-1]),
    .rab_mst_req_valid (t_req_valid[N_TGT-1]),
    .rab_mst_req_ready (t_req_ready[N_TGT-1]),
    .rab_mst_rsp       (t_rsp[N_TGT-1]),
    .rab_mst_rsp_valid (t_rsp_valid[N_TGT-1]),
    .rab_mst_rsp_ready (t_rsp_ready[N_TGT-1])
  );

  task automatic check_mst_req(input string name, input soc_bus_pkg::mst_req_t got,
                               input soc_bus_pkg::mst_req_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_slv_rsp(input string name, input soc_bus_pkg::slv_rsp_t got,
                               input soc_bus_pkg::slv_rsp_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // Address map model: cluster windows, L2 ports, everything else to RAB
  function automatic int model_tgt(input soc_bus_pkg::addr_t a);
    logic [31:0] rel;
    if (a >= `SOC_CLUSTER_BASE && a < `SOC_CLUSTER_BASE + N_CL * `SOC_CLUSTER_STRIDE) begin
      rel = a - `SOC_CLUSTER_BASE;
      if (rel % `SOC_CLUSTER_STRIDE < `SOC_CLUSTER_SIZE) return int'(rel / `SOC_CLUSTER_STRIDE);
      return N_TGT - 1;
    end
    if (a >= `SOC_L2_BASE && a < `SOC_L2_BASE + N_L2 * `SOC_L2_BYTES_PER_PORT) begin
      return N_CL + int'((a - `SOC_L2_BASE) / `SOC_L2_BYTES_PER_PORT);
    end
    return N_TGT - 1;
  endfunction

  task automatic accept_request(input int t);
    soc_bus_pkg::mst_rsp_t rsp;
    int src;
    src = int'(t_req[t].id[OUP_ID_W-1 -: REQ_IDX_W]);
    accepts[t]++;
    grant_log[t].push_back(src);
    rr_model[t] = (src + 1) % N_REQ;
    if (exp_q[t].size() == 0) begin
      errors++;
      $display("Unexpected request at target %0d from requester %0d", t, src);
    end else begin
      check_mst_req($sformatf("t_req[%0d]", t), t_req[t], exp_q[t].pop_front());
    end
    rsp.rdata = t_req[t].addr ^ RD_KEY;
    rsp.id    = t_req[t].id;
    rsp_q[t].push_back(rsp);
    due_q[t].push_back(cycle + RSP_DELAY);
  endtask

  // Target models with a fixed response delay
  always @(posedge clk_i) begin
    cycle++;
    for (int t = 0; t < N_TGT; t++) begin
      if (reset) begin
        rsp_q[t].delete();
        due_q[t].delete();
        rr_model[t] = 0;
      end else begin
        if (t_rsp_valid[t] && t_rsp_ready[t]) begin
          void'(rsp_q[t].pop_front());
          void'(due_q[t].pop_front());
        end
        if (t_req_valid[t] && t_req_ready[t]) accept_request(t);
      end
    end
    #2;
    for (int t = 0; t < N_TGT; t++) begin
      t_rsp_valid[t] = (rsp_q[t].size() > 0) && (due_q[t][0] <= cycle);
      t_rsp[t] = t_rsp_valid[t] ? rsp_q[t][0] : '0;
    end
  end

  // One transaction from requester r, with optional routing check
  task automatic transact(input int r, input soc_bus_pkg::addr_t a,
                          input soc_bus_pkg::id_inp_t id, input bit check_path);
    soc_bus_pkg::slv_req_t q;
    soc_bus_pkg::mst_req_t e;
    soc_bus_pkg::slv_rsp_t exp;
    int n;
    int t;
    t = model_tgt(a);
    q.addr = a;
    q.we = a[2];
    q.wdata = ~a;
    q.id = id;
    e.addr = a;
    e.we = q.we;
    e.wdata = q.wdata;
    e.id = {REQ_IDX_W'(r), id};
    exp.rdata = a ^ RD_KEY;
    exp.id = id;
    r_req[r] = q;
    r_valid[r] = 1'b1;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!r_ready[r] && n < MAX_WAIT);
    if (!r_ready[r]) begin
      errors++;
      $display("Requester %0d request to 0x%h was never accepted", r, a);
      #2 r_valid[r] = 1'b0;
      return;
    end
    exp_q[t].push_back(e);
    #2;
    r_valid[r] = 1'b0;
    if (check_path && t_req_valid !== N_TGT'(1) << t) begin
      errors++;
      $display("Error t_req_valid got 0x%h expected 0x%h", t_req_valid, N_TGT'(1) << t);
    end
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!(r_rsp_valid[r] && r_rsp_ready[r]) && n < MAX_WAIT);
    if (!(r_rsp_valid[r] && r_rsp_ready[r])) begin
      errors++;
      $display("Requester %0d got no response for address 0x%h", r, a);
    end else begin
      check_slv_rsp($sformatf("r_rsp[%0d]", r), r_rsp[r], exp);
    end
    #2;
  endtask

  task automatic routing_test();
    soc_bus_pkg::addr_t addrs[9] = '{32'h0000_1000, 32'h1000_0100, 32'h1040_0200,
                                     32'h1070_0000, 32'h1030_0000, 32'h1A00_0010,
                                     32'h1C00_0020, 32'h1C01_0030, 32'h1C02_0004};
    for (int r = 0; r < N_REQ; r++) begin
      for (int i = 0; i < 9; i++) begin
        transact(r, addrs[i], soc_bus_pkg::id_inp_t'(i), 1'b1);
      end
    end
  endtask

  // Two clusters to L2 port 0, first winner follows the round-robin pointer
  task automatic arbitration_test();
    int t;
    int first;
    int idx;
    t = N_CL;
    for (int rep = 0; rep < 4; rep++) begin
      // Lone request moves the pointer, so the first winner alternates per repeat
      transact(1 - rep % 2, `SOC_L2_BASE + 32'h180 + rep * 8, 2'd0, 1'b0);
      first = -1;
      for (int k = 0; k < N_REQ; k++) begin
        idx = (rr_model[t] + k) % N_REQ;
        if (first < 0 && idx < 2) first = idx;
      end
      grant_log[t].delete();
      fork
        transact(0, `SOC_L2_BASE + 32'h100 + rep * 8, 2'd1, 1'b0);
        transact(1, `SOC_L2_BASE + 32'h104 + rep * 8, 2'd2, 1'b0);
      join
      if (grant_log[t].size() != 2 || grant_log[t][0] != first ||
          grant_log[t][1] != 1 - first) begin
        errors++;
        $display("Arbitration repeat %0d did not serve both clusters in order", rep);
      end
    end
  endtask

  task automatic backpressure_test();
    soc_bus_pkg::mst_req_t held;
    int t;
    int n0;
    t = N_CL + 1;
    t_req_ready[t] = 1'b0;
    fork
      transact(1, `SOC_L2_BASE + `SOC_L2_BYTES_PER_PORT + 32'h40, 2'd1, 1'b0);
      transact(0, `SOC_L2_BASE + `SOC_L2_BYTES_PER_PORT + 32'h44, 2'd2, 1'b0);
      begin
        @(posedge clk_i);
        #2 held = t_req[t];
        repeat (4) begin
          @(posedge clk_i);
          #2;
          if (!t_req_valid[t] || t_req[t] !== held || (|r_ready[N_CL-1:0])) begin
            errors++;
            $display("Stalled request at target %0d was not held", t);
          end
        end
        n0 = accepts[t];
        t_req_ready[t] = 1'b1;
        @(posedge clk_i);
        #1;
        if (accepts[t] != n0 + 1) begin
          errors++;
          $display("Release of target %0d gave %0d transfers", t, accepts[t] - n0);
        end
      end
    join
  endtask

  task automatic response_stall_test();
    r_rsp_ready[0] = 1'b0;
    fork
      transact(0, `SOC_CLUSTER_BASE + `SOC_CLUSTER_STRIDE + 32'h80, 2'd3, 1'b0);
      begin
        repeat (RSP_DELAY + 6) @(posedge clk_i);
        #2;
        if (!t_rsp_valid[1] || t_rsp_ready[1] || !r_rsp_valid[0]) begin
          errors++;
          $display("Response stall at target 1 was not held");
        end
        r_rsp_ready[0] = 1'b1;
      end
    join
  endtask

  function automatic soc_bus_pkg::addr_t rand_addr();
    int unsigned region;
    region = $urandom % 5;
    case (region)
      0: return $urandom % `SOC_CLUSTER_BASE;
      1: return `SOC_CLUSTER_BASE + ($urandom % (N_CL * `SOC_CLUSTER_STRIDE));
      2: return `SOC_PERIPH_BASE + ($urandom % 32'h0100_0000);
      3: return `SOC_L2_BASE + ($urandom % (N_L2 * `SOC_L2_BYTES_PER_PORT));
      default: return $urandom;
    endcase
  endfunction

  task automatic random_stream(input int r, input int n);
    for (int i = 0; i < n; i++) begin
      transact(r, rand_addr(), soc_bus_pkg::id_inp_t'($urandom), 1'b0);
    end
  endtask

  initial begin
    void'($urandom(32'h5990_299d));
    reset = 1'b1;
    r_req = '0;
    r_valid = '0;
    r_rsp_ready = '1;
    t_req_ready = '1;
    repeat (16) @(posedge clk_i);
    #2 reset = 1'b0;
    routing_test();
    arbitration_test();
    backpressure_test();
    response_stall_test();
    fork
      random_stream(0, 67);
      random_stream(1, 67);
      random_stream(2, 66);
    join
    repeat (4) @(posedge clk_i);
    for (int t = 0; t < N_TGT; t++) begin
      if (exp_q[t].size() != 0 || rsp_q[t].size() != 0) begin
        errors++;
        $display("Target %0d still has transactions left over", t);
      end
    end
    errors += uut.i_assertions.fail_count;
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from test count and worst case cycles per test
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* tb/soc_bus_assertions.sv */
// Bound assertions for soc_bus handshake stability, reset values and response count
`include "soc_bus_settings.svh"

module soc_bus_assertions (
  input logic                                        clk_i,
  input logic                                        reset,
  input logic                  [`SOC_N_CLUSTERS-1:0] cl_slv_req_valid,
  input logic                  [`SOC_N_CLUSTERS-1:0] cl_slv_req_ready,
  input logic                  [`SOC_N_CLUSTERS-1:0] cl_slv_rsp_valid,
  input logic                  [`SOC_N_CLUSTERS-1:0] cl_slv_rsp_ready,
  input logic                                        rab_slv_req_valid,
  input logic                                        rab_slv_req_ready,
  input logic                                        rab_slv_rsp_valid,
  input logic                                        rab_slv_rsp_ready,
  input soc_bus_pkg::mst_req_t [`SOC_N_CLUSTERS-1:0] cl_mst_req,
  input logic                  [`SOC_N_CLUSTERS-1:0] cl_mst_req_valid,
  input logic                  [`SOC_N_CLUSTERS-1:0] cl_mst_req_ready,
  input soc_bus_pkg::mst_req_t [`SOC_L2_N_PORTS-1:0] l2_mst_req,
  input logic                  [`SOC_L2_N_PORTS-1:0] l2_mst_req_valid,
  input logic                  [`SOC_L2_N_PORTS-1:0] l2_mst_req_ready,
  input soc_bus_pkg::mst_req_t                       rab_mst_req,
  input logic                                        rab_mst_req_valid,
  input logic                                        rab_mst_req_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_REQ = soc_bus_pkg::N_REQUESTERS;
  localparam int N_TGT = soc_bus_pkg::N_TARGETS;

  soc_bus_pkg::mst_req_t [N_TGT-1:0] tgt_req;
  logic [N_TGT-1:0] tgt_valid;
  logic [N_TGT-1:0] tgt_ready;
  logic [N_REQ-1:0] req_fire;
  logic [N_REQ-1:0] rsp_valid;
  logic [N_REQ-1:0] rsp_fire;
  logic [N_REQ-1:0] outstanding;
  int fail_count = 0;

  assign tgt_req   = {rab_mst_req, l2_mst_req, cl_mst_req};
  assign tgt_valid = {rab_mst_req_valid, l2_mst_req_valid, cl_mst_req_valid};
  assign tgt_ready = {rab_mst_req_ready, l2_mst_req_ready, cl_mst_req_ready};
  assign req_fire  = {rab_slv_req_valid, cl_slv_req_valid} & {rab_slv_req_ready, cl_slv_req_ready};
  assign rsp_valid = {rab_slv_rsp_valid, cl_slv_rsp_valid};
  assign rsp_fire  = rsp_valid & {rab_slv_rsp_ready, cl_slv_rsp_ready};

  // One request in flight per requester
  always_ff @(posedge clk_i) begin
    if (reset) begin
      outstanding <= '0;
    end else begin
      outstanding <= (outstanding | req_fire) & ~rsp_fire;
    end
  end

  for (genvar t = 0; t < N_TGT; t++) begin : gen_tgt
    hold_stable: assert property (@(posedge clk_i) disable iff (reset)
      tgt_valid[t] && !tgt_ready[t] |=> tgt_valid[t] && $stable(tgt_req[t]))
      else begin
        fail_count++;
        $error("Target %0d request changed while stalled", t);
      end
  end

  reset_quiet: assert property (@(posedge clk_i) reset |=> !(|tgt_valid) && !(|rsp_valid))
    else begin
      fail_count++;
      $error("Valid output high after reset");
    end

  for (genvar r = 0; r < N_REQ; r++) begin : gen_req
    one_rsp: assert property (@(posedge clk_i) disable iff (reset) rsp_fire[r] |-> outstanding[r])
      else begin
        fail_count++;
        $error("Requester %0d got a response with no request in flight", r);
      end
  end

endmodule

bind soc_bus soc_bus_assertions i_assertions (.*);

/* source/soc_bus.sv */
// Interconnect top module wiring one demux per requester to one mux per target
`include "soc_bus_settings.svh"

module soc_bus (
  input  logic                                           clk_i,
  input  logic                                           reset,
  input  soc_bus_pkg::slv_req_t [`SOC_N_CLUSTERS-1:0]    cl_slv_req,
  input  logic                  [`SOC_N_CLUSTERS-1:0]    cl_slv_req_valid,
  output logic                  [`SOC_N_CLUSTERS-1:0]    cl_slv_req_ready,
  output soc_bus_pkg::slv_rsp_t [`SOC_N_CLUSTERS-1:0]    cl_slv_rsp,
  output logic                  [`SOC_N_CLUSTERS-1:0]    cl_slv_rsp_valid,
  input  logic                  [`SOC_N_CLUSTERS-1:0]    cl_slv_rsp_ready,
  input  soc_bus_pkg::slv_req_t                          rab_slv_req,
  input  logic                                           rab_slv_req_valid,
  output logic                                           rab_slv_req_ready,
  output soc_bus_pkg::slv_rsp_t                          rab_slv_rsp,
  output logic                                           rab_slv_rsp_valid,
  input  logic                                           rab_slv_rsp_ready,
  output soc_bus_pkg::mst_req_t [`SOC_N_CLUSTERS-1:0]    cl_mst_req,
  output logic                  [`SOC_N_CLUSTERS-1:0]    cl_mst_req_valid,
  input  logic                  [`SOC_N_CLUSTERS-1:0]    cl_mst_req_ready,
  input  soc_bus_pkg::mst_rsp_t [`SOC_N_CLUSTERS-1:0]    cl_mst_rsp,
  input  logic                  [`SOC_N_CLUSTERS-1:0]    cl_mst_rsp_valid,
  output logic                  [`SOC_N_CLUSTERS-1:0]    cl_mst_rsp_ready,
  output soc_bus_pkg::mst_req_t [`SOC_L2_N_PORTS-1:0]    l2_mst_req,
  output logic                  [`SOC_L2_N_PORTS-1:0]    l2_mst_req_valid,
  input  logic                  [`SOC_L2_N_PORTS-1:0]    l2_mst_req_ready,
  input  soc_bus_pkg::mst_rsp_t [`SOC_L2_N_PORTS-1:0]    l2_mst_rsp,
  input  logic                  [`SOC_L2_N_PORTS-1:0]    l2_mst_rsp_valid,
  output logic                  [`SOC_L2_N_PORTS-1:0]    l2_mst_rsp_ready,
  output soc_bus_pkg::mst_req_t                          rab_mst_req,
  output logic                                           rab_mst_req_valid,
  input  logic                                           rab_mst_req_ready,
  input  soc_bus_pkg::mst_rsp_t                          rab_mst_rsp,
  input  logic                                           rab_mst_rsp_valid,
  output logic                                           rab_mst_rsp_ready
);

  localparam int unsigned N_REQ = soc_bus_pkg::N_REQUESTERS;
  localparam int unsigned N_TGT = soc_bus_pkg::N_TARGETS;

  // Requester side, clusters first, host bridge last
  soc_bus_pkg::slv_req_t [N_REQ-1:0] req;
  logic                  [N_REQ-1:0] req_valid;
  logic                  [N_REQ-1:0] req_ready;
  soc_bus_pkg::slv_rsp_t [N_REQ-1:0] rsp;
  logic                  [N_REQ-1:0] rsp_valid;
  logic                  [N_REQ-1:0] rsp_ready;

  // Target side, clusters, then L2 ports, then host bridge
  soc_bus_pkg::mst_req_t [N_TGT-1:0] tgt_req;
  logic                  [N_TGT-1:0] tgt_req_valid;
  logic                  [N_TGT-1:0] tgt_req_ready;
  soc_bus_pkg::mst_rsp_t [N_TGT-1:0] tgt_rsp;
  logic                  [N_TGT-1:0] tgt_rsp_valid;
  logic                  [N_TGT-1:0] tgt_rsp_ready;

  // Crossbar handshakes, seen from the demux and from the mux side
  logic [N_REQ-1:0][N_TGT-1:0] dmx_req_valid;
  logic [N_REQ-1:0][N_TGT-1:0] dmx_req_ready;
  logic [N_REQ-1:0][N_TGT-1:0] dmx_rsp_valid;
  logic [N_REQ-1:0][N_TGT-1:0] dmx_rsp_ready;
  logic [N_TGT-1:0][N_REQ-1:0] mux_req_valid;
  logic [N_TGT-1:0][N_REQ-1:0] mux_req_ready;
  logic [N_TGT-1:0][N_REQ-1:0] mux_rsp_valid;
  logic [N_TGT-1:0][N_REQ-1:0] mux_rsp_ready;
  soc_bus_pkg::slv_rsp_t [N_TGT-1:0] mux_rsp;

  assign req       = {rab_slv_req, cl_slv_req};
  assign req_valid = {rab_slv_req_valid, cl_slv_req_valid};
  assign rsp_ready = {rab_slv_rsp_ready, cl_slv_rsp_ready};
  assign {rab_slv_req_ready, cl_slv_req_ready} = req_ready;
  assign {rab_slv_rsp, cl_slv_rsp}             = rsp;
  assign {rab_slv_rsp_valid, cl_slv_rsp_valid} = rsp_valid;

  assign {rab_mst_req, l2_mst_req, cl_mst_req}                   = tgt_req;
  assign {rab_mst_req_valid, l2_mst_req_valid, cl_mst_req_valid} = tgt_req_valid;
  assign {rab_mst_rsp_ready, l2_mst_rsp_ready, cl_mst_rsp_ready} = tgt_rsp_ready;
  assign tgt_req_ready = {rab_mst_req_ready, l2_mst_req_ready, cl_mst_req_ready};
  assign tgt_rsp       = {rab_mst_rsp, l2_mst_rsp, cl_mst_rsp};
  assign tgt_rsp_valid = {rab_mst_rsp_valid, l2_mst_rsp_valid, cl_mst_rsp_valid};

  for (genvar r = 0; r < N_REQ; r++) begin : gen_xpose_req
    for (genvar t = 0; t < N_TGT; t++) begin : gen_xpose_tgt
      assign mux_req_valid[t][r] = dmx_req_valid[r][t];
      assign dmx_req_ready[r][t] = mux_req_ready[t][r];
      assign dmx_rsp_valid[r][t] = mux_rsp_valid[t][r];
      assign mux_rsp_ready[t][r] = dmx_rsp_ready[r][t];
    end
  end

  for (genvar r = 0; r < N_REQ; r++) begin : gen_demux
    soc_bus_demux i_demux (
      .clk_i,
      .reset,
      .slv_req       (req[r]),
      .slv_req_valid (req_valid[r]),
      .slv_req_ready (req_ready[r]),
      .slv_rsp       (rsp[r]),
      .slv_rsp_valid (rsp_valid[r]),
      .slv_rsp_ready (rsp_ready[r]),
      .tgt_req_valid (dmx_req_valid[r]),
      .tgt_req_ready (dmx_req_ready[r]),
      .tgt_rsp       (mux_rsp),
      .tgt_rsp_valid (dmx_rsp_valid[r]),
      .tgt_rsp_ready (dmx_rsp_ready[r])
    );
  end

  for (genvar t = 0; t < N_TGT; t++) begin : gen_mux
    soc_bus_mux i_mux (
      .clk_i,
      .reset,
      .src_req       (req),
      .src_req_valid (mux_req_valid[t]),
      .src_req_ready (mux_req_ready[t]),
      .src_rsp       (mux_rsp[t]),
      .src_rsp_valid (mux_rsp_valid[t]),
      .src_rsp_ready (mux_rsp_ready[t]),
      .mst_req       (tgt_req[t]),
      .mst_req_valid (tgt_req_valid[t]),
      .mst_req_ready (tgt_req_ready[t]),
      .mst_rsp       (tgt_rsp[t]),
      .mst_rsp_valid (tgt_rsp_valid[t]),
      .mst_rsp_ready (tgt_rsp_ready[t])
    );
  end

endmodule

/* source/soc_bus_mux.sv */
// Per-target mux module with round-robin arbiter, output register and response routing
`include "soc_bus_settings.svh"

module soc_bus_mux (
  input  logic                                                 clk_i,
  input  logic                                                 reset,
  input  soc_bus_pkg::slv_req_t [soc_bus_pkg::N_REQUESTERS-1:0] src_req,
  input  logic                  [soc_bus_pkg::N_REQUESTERS-1:0] src_req_valid,
  output logic                  [soc_bus_pkg::N_REQUESTERS-1:0] src_req_ready,
  output soc_bus_pkg::slv_rsp_t                                src_rsp,
  output logic                  [soc_bus_pkg::N_REQUESTERS-1:0] src_rsp_valid,
  input  logic                  [soc_bus_pkg::N_REQUESTERS-1:0] src_rsp_ready,
  output soc_bus_pkg::mst_req_t                                mst_req,
  output logic                                                 mst_req_valid,
  input  logic                                                 mst_req_ready,
  input  soc_bus_pkg::mst_rsp_t                                mst_rsp,
  input  logic                                                 mst_rsp_valid,
  output logic                                                 mst_rsp_ready
);

  localparam int unsigned N_REQ = soc_bus_pkg::N_REQUESTERS;
  localparam int unsigned REQ_IDX_W = soc_bus_pkg::REQ_IDX_W;
  localparam int unsigned OUP_ID_W = soc_bus_pkg::OUP_ID_W;

  logic [REQ_IDX_W-1:0]  rr_ptr;
  logic [REQ_IDX_W-1:0]  grant_idx;
  logic [REQ_IDX_W-1:0]  next_ptr;
  logic                  grant_valid;
  logic                  out_valid;
  logic                  out_ready;
  logic                  load;
  soc_bus_pkg::mst_req_t out_req;
  soc_bus_pkg::slv_req_t win_req;
  logic [REQ_IDX_W-1:0]  rsp_src;
  logic                  rsp_src_ok;

  // Round robin, search starts at the requester after the last winner
  always_comb begin
    int unsigned idx;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int unsigned k = 0; k < N_REQ; k++) begin
      idx = (32'(rr_ptr) + k) % N_REQ;
      if (!grant_valid && src_req_valid[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = REQ_IDX_W'(idx);
      end
    end
  end

  assign next_ptr = (32'(grant_idx) == N_REQ - 1) ? '0 : grant_idx + 1'b1;

  // Output register takes a new entry when empty or draining this cycle
  assign out_ready = !out_valid || mst_req_ready;
  assign load      = out_ready && grant_valid;

  always_comb begin
    src_req_ready            = '0;
    src_req_ready[grant_idx] = load;
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      out_valid <= 1'b0;
      rr_ptr    <= '0;
    end else if (load) begin
      out_valid <= 1'b1;
      rr_ptr    <= next_ptr;
    end else if (mst_req_ready) begin
      out_valid <= 1'b0;
    end
  end

  assign win_req = src_req[grant_idx];

  // Requester index goes in front of the original ID
  always_ff @(posedge clk_i) begin
    if (load) begin
      out_req.addr  <= win_req.addr;
      out_req.we    <= win_req.we;
      out_req.wdata <= win_req.wdata;
      out_req.id    <= {grant_idx, win_req.id};
    end
  end

  assign mst_req       = out_req;
  assign mst_req_valid = out_valid;

  // Response goes straight back, steered by the upper ID bits
  assign rsp_src    = mst_rsp.id[OUP_ID_W-1 -: REQ_IDX_W];
  assign rsp_src_ok = (32'(rsp_src) < N_REQ);

  assign src_rsp.rdata = mst_rsp.rdata;
  assign src_rsp.id    = mst_rsp.id[`SOC_ID_W_INP-1:0];

  always_comb begin
    src_rsp_valid = '0;
    if (rsp_src_ok) begin
      src_rsp_valid[rsp_src] = mst_rsp_valid;
    end
  end

  assign mst_rsp_ready = rsp_src_ok && src_rsp_ready[rsp_src];

endmodule

/* source/soc_bus_demux.sv */
// Per-requester demux module with address decode and outstanding-target tracking
module soc_bus_demux (
  input  logic                                              clk_i,
  input  logic                                              reset,
  input  soc_bus_pkg::slv_req_t                             slv_req,
  input  logic                                              slv_req_valid,
  output logic                                              slv_req_ready,
  output soc_bus_pkg::slv_rsp_t                             slv_rsp,
  output logic                                              slv_rsp_valid,
  input  logic                                              slv_rsp_ready,
  output logic                  [soc_bus_pkg::N_TARGETS-1:0] tgt_req_valid,
  input  logic                  [soc_bus_pkg::N_TARGETS-1:0] tgt_req_ready,
  input  soc_bus_pkg::slv_rsp_t [soc_bus_pkg::N_TARGETS-1:0] tgt_rsp,
  input  logic                  [soc_bus_pkg::N_TARGETS-1:0] tgt_rsp_valid,
  output logic                  [soc_bus_pkg::N_TARGETS-1:0] tgt_rsp_ready
);

  soc_bus_pkg::soc_addr_u req_addr;
  soc_bus_pkg::tgt_idx_t  dec_tgt;
  soc_bus_pkg::tgt_idx_t  pend_tgt;
  logic                   pending;
  logic                   req_fire;
  logic                   rsp_fire;

  assign req_addr = slv_req.addr;

  soc_addr_decoder i_decoder (
    .addr (req_addr),
    .tgt  (dec_tgt)
  );

  // Valid goes to the decoded mux only, and only while nothing is in flight
  always_comb begin
    tgt_req_valid = '0;
    slv_req_ready = 1'b0;
    if (!pending) begin
      tgt_req_valid[dec_tgt] = slv_req_valid;
      slv_req_ready          = tgt_req_ready[dec_tgt];
    end
  end

  assign req_fire = slv_req_valid && slv_req_ready;
  assign rsp_fire = slv_rsp_valid && slv_rsp_ready;

  // Outstanding target, held from acceptance until the response handshake
  always_ff @(posedge clk_i) begin
    if (reset) begin
      pending  <= 1'b0;
      pend_tgt <= '0;
    end else if (req_fire) begin
      pending  <= 1'b1;
      pend_tgt <= dec_tgt;
    end else if (rsp_fire) begin
      pending  <= 1'b0;
    end
  end

  // Response path, only from the target we are waiting on
  assign slv_rsp       = tgt_rsp[pend_tgt];
  assign slv_rsp_valid = pending && tgt_rsp_valid[pend_tgt];

  always_comb begin
    tgt_rsp_ready           = '0;
    tgt_rsp_ready[pend_tgt] = pending && slv_rsp_ready;
  end

endmodule

/* source/soc_addr_decoder.sv */
// Address decoder module mapping a request address to a target port index
`include "soc_bus_settings.svh"

module soc_addr_decoder (
  input  soc_bus_pkg::soc_addr_u addr,
  output soc_bus_pkg::tgt_idx_t  tgt
);

  // Bit position of the lowest tag bit in each view
  localparam int unsigned CL_LSB = soc_bus_pkg::CL_IDX_W + soc_bus_pkg::CL_OFF_W;
  localparam int unsigned L2_LSB = soc_bus_pkg::L2_IDX_W + soc_bus_pkg::L2_OFF_W;

  // Tag values of the cluster block and of the L2 block
  localparam logic [`SOC_ADDR_W-1:0] CL_TAG = `SOC_CLUSTER_BASE >> CL_LSB;
  localparam logic [`SOC_ADDR_W-1:0] L2_TAG = `SOC_L2_BASE >> L2_LSB;

  logic cl_tag_hit;
  logic cl_idx_hit;
  logic cl_off_hit;
  logic cl_hit;
  logic l2_tag_hit;
  logic l2_idx_hit;
  logic l2_hit;

  // Cluster window
  // Upper part of each stride beyond the window size is a gap
  always_comb begin
    cl_tag_hit = (addr.cluster_view.tag == CL_TAG[soc_bus_pkg::CL_TAG_W-1:0]);
    cl_idx_hit = (32'(addr.cluster_view.idx) < `SOC_N_CLUSTERS);
    cl_off_hit = (32'(addr.cluster_view.offset) < `SOC_CLUSTER_SIZE);
    cl_hit     = cl_tag_hit && cl_idx_hit && cl_off_hit;
  end

  // L2 range, one port per block of SOC_L2_BYTES_PER_PORT
  always_comb begin
    l2_tag_hit = (addr.l2_view.tag == L2_TAG[soc_bus_pkg::L2_TAG_W-1:0]);
    l2_idx_hit = (32'(addr.l2_view.idx) < `SOC_L2_N_PORTS);
    l2_hit     = l2_tag_hit && l2_idx_hit;
  end

  // Below clusters, gaps, periph and above L2 all end at the host bridge
  always_comb begin
    if (cl_hit) begin
      tgt = soc_bus_pkg::tgt_idx_t'(addr.cluster_view.idx);
    end else if (l2_hit) begin
      tgt = soc_bus_pkg::tgt_idx_t'(soc_bus_pkg::TGT_IDX_L2 + 32'(addr.l2_view.idx));
    end else begin
      tgt = soc_bus_pkg::tgt_idx_t'(soc_bus_pkg::TGT_IDX_RAB);
    end
  end

endmodule

/* source/soc_bus_pkg.sv */
// Port-count helper functions, derived constants and the bus request, response and address types
`include "soc_bus_settings.svh"

package soc_bus_pkg;

  function automatic int unsigned n_requesters(input int unsigned n_clusters);
    return n_clusters + 1;
  endfunction

  function automatic int unsigned n_targets(input int unsigned n_clusters,
                                            input int unsigned l2_n_ports);
    return n_clusters + l2_n_ports + 1;
  endfunction

  // Index width, at least one bit
  function automatic int unsigned idx_w(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  function automatic int unsigned oup_id_w(input int unsigned n_clusters,
                                           input int unsigned inp_id_w);
    return inp_id_w + idx_w(n_requesters(n_clusters));
  endfunction

  localparam int unsigned N_REQUESTERS = n_requesters(`SOC_N_CLUSTERS);
  localparam int unsigned N_TARGETS = n_targets(`SOC_N_CLUSTERS, `SOC_L2_N_PORTS);
  localparam int unsigned REQ_IDX_W = idx_w(N_REQUESTERS);
  localparam int unsigned OUP_ID_W = oup_id_w(`SOC_N_CLUSTERS, `SOC_ID_W_INP);

  // Target order: clusters, L2 ports, host bridge
  localparam int unsigned TGT_IDX_L2 = `SOC_N_CLUSTERS;
  localparam int unsigned TGT_IDX_RAB = N_TARGETS - 1;

  // Field widths of the two address views
  localparam int unsigned CL_IDX_W = idx_w(`SOC_N_CLUSTERS);
  localparam int unsigned CL_OFF_W = $clog2(`SOC_CLUSTER_STRIDE);
  localparam int unsigned CL_TAG_W = `SOC_ADDR_W - CL_IDX_W - CL_OFF_W;
  localparam int unsigned L2_IDX_W = idx_w(`SOC_L2_N_PORTS);
  localparam int unsigned L2_OFF_W = $clog2(`SOC_L2_BYTES_PER_PORT);
  localparam int unsigned L2_TAG_W = `SOC_ADDR_W - L2_IDX_W - L2_OFF_W;

  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;
  typedef logic [`SOC_ID_W_INP-1:0] id_inp_t;
  typedef logic [OUP_ID_W-1:0] id_oup_t;
  typedef logic [2:0] tgt_idx_t;

  typedef struct packed {
    logic [CL_TAG_W-1:0] tag;
    logic [CL_IDX_W-1:0] idx;
    logic [CL_OFF_W-1:0] offset;
  } cluster_view_t;

  typedef struct packed {
    logic [L2_TAG_W-1:0] tag;
    logic [L2_IDX_W-1:0] idx;
    logic [L2_OFF_W-1:0] offset;
  } l2_view_t;

  // One address word, read either as a cluster window or as an L2 location
  typedef union packed {
    addr_t         word;
    cluster_view_t cluster_view;
    l2_view_t      l2_view;
  } soc_addr_u;

  typedef struct packed {
    addr_t   addr;
    logic    we;
    data_t   wdata;
    id_inp_t id;
  } slv_req_t;

  typedef struct packed {
    addr_t   addr;
    logic    we;
    data_t   wdata;
    id_oup_t id;
  } mst_req_t;

  typedef struct packed {
    data_t   rdata;
    id_inp_t id;
  } slv_rsp_t;

  typedef struct packed {
    data_t   rdata;
    id_oup_t id;
  } mst_rsp_t;

endpackage

/* source/soc_bus_settings.svh */
// Port counts, bus widths and address map constants of the SoC interconnect
`ifndef SOC_BUS_SETTINGS_SVH
`define SOC_BUS_SETTINGS_SVH

// Port counts
`define SOC_N_CLUSTERS 2
`define SOC_L2_N_PORTS 2

// Bytes behind each L2 port, a power of two
`define SOC_L2_BYTES_PER_PORT 32'h0001_0000

// Bus widths in bits
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_ID_W_INP 2

// Cluster windows
// Stride is a power of two and the base is aligned to all cluster windows
`define SOC_CLUSTER_BASE 32'h1000_0000
`define SOC_CLUSTER_STRIDE 32'h0040_0000
`define SOC_CLUSTER_SIZE 32'h0030_0000

// Peripheral region, served by the host bridge
`define SOC_PERIPH_BASE 32'h1A00_0000
`define SOC_PERIPH_END 32'h1AFF_FFFF

// L2 memory, base aligned to the size of all L2 ports together
`define SOC_L2_BASE 32'h1C00_0000

`endif
